/* Bender.yml */
package:
  name: disk_bridge

sources:
  - design/disk_bridge_pkg.sv
  - design/host_port.sv
  - design/sector_buffer.sv
  - design/sd_requester.sv
  - design/mount_tracker.sv
  - design/disk_bridge_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/disk_bridge_checker.sv
      - test/tb_disk_bridge.sv

/* design/disk_bridge_pkg.sv */
// Shared types and constants for the disk block bridge.
// Every bridge module takes this package by a wildcard import in its header.

`default_nettype none

package disk_bridge_pkg;

	// ======================================================================
	// Sizes and slot numbering
	// ======================================================================

	// Drive request slots D1, D2 and cartridge
	localparam int num_drives = 3;

	// Default sector buffer address width, 512 bytes
	localparam int buf_aw = 9;

	// File numbers reported to the host for each slot
	localparam logic [2:0] fileno_d1   = 3'd0;
	localparam logic [2:0] fileno_d2   = 3'd1;
	localparam logic [2:0] fileno_cart = 3'd4;

	typedef logic [1:0] drive_idx_t;
	typedef logic [2:0] host_drive_t;

	// ======================================================================
	// Host side words
	// ======================================================================

	// Control word, lba_sel sits in bit 0
	typedef struct packed {
		host_drive_t drive;
		logic        block_wr;
		logic        block_rd;
		logic        lba_sel;
	} host_ctrl_t;

	typedef struct packed {
		logic [23:0] pad;
		logic [7:0]  value;
	} host_byte_t;

	// Data word is either a full LBA or a single buffer byte
	typedef union packed {
		logic [31:0] lba;
		host_byte_t  octet;
	} host_word_u;

	// Status byte, io_done in bit 0 and readonly in bit 7
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} host_status_t;

	// Attributes of the most recently mounted image
	typedef struct packed {
		logic        mounted;
		logic [2:0]  fileno;
		logic [1:0]  filetype;
		logic        readonly;
		logic [31:0] filesize;
	} mount_info_t;

endpackage

`default_nettype wire

/* design/disk_bridge_top.sv */
// Top level of the disk block bridge.
// Joins the host register port, the sector buffer, the SD request side
// and the mount tracker, and sets the buffer address width for all.

`default_nettype none

module disk_bridge_top import disk_bridge_pkg::*; #(
	parameter int BUF_AW = buf_aw
) (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,

	// Host side
	input  wire host_ctrl_t            host_ctrl,
	input  wire host_word_u            host_data,
	input  wire logic                  io_wr,
	input  wire logic                  data_wr,
	input  wire logic                  data_rd,
	output host_status_t               host_status,
	output logic [31:0]                host_rdata,

	// SD image service
	input  wire logic [num_drives-1:0] sd_ack,
	input  wire logic [BUF_AW-1:0]     sd_buff_addr,
	input  wire logic [7:0]            sd_buff_wdata,
	input  wire logic                  sd_buff_wr,
	input  wire logic [num_drives-1:0] img_mounted,
	input  wire logic                  img_readonly,
	input  wire logic [31:0]           img_size,
	input  wire logic [1:0]            img_type,
	output logic [31:0]                sd_lba,
	output logic [num_drives-1:0]      sd_rd,
	output logic [num_drives-1:0]      sd_wr,
	output logic [7:0]                 sd_buff_rdata
);

	// Host port to buffer
	logic       buf_push;
	logic [7:0] buf_wdata;
	logic       buf_pop;
	logic       buf_rewind;
	logic [7:0] buf_rdata;

	// Host port to SD request side
	logic       rd_req;
	logic       wr_req;
	drive_idx_t req_drive;
	logic       io_done;

	mount_info_t mount;

	host_port #(
		.BUF_AW(BUF_AW)
	) u_host_port (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.host_ctrl  (host_ctrl),
		.host_data  (host_data),
		.io_wr      (io_wr),
		.data_wr    (data_wr),
		.data_rd    (data_rd),
		.buf_rdata  (buf_rdata),
		.io_done    (io_done),
		.mount      (mount),
		.buf_push   (buf_push),
		.buf_wdata  (buf_wdata),
		.buf_pop    (buf_pop),
		.buf_rewind (buf_rewind),
		.rd_req     (rd_req),
		.wr_req     (wr_req),
		.req_drive  (req_drive),
		.sd_lba     (sd_lba),
		.host_status(host_status),
		.host_rdata (host_rdata)
	);

	sector_buffer #(
		.BUF_AW(BUF_AW)
	) u_sector_buffer (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.buf_push     (buf_push),
		.buf_wdata    (buf_wdata),
		.buf_pop      (buf_pop),
		.buf_rewind   (buf_rewind),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_wdata(sd_buff_wdata),
		.sd_buff_wr   (sd_buff_wr),
		.buf_rdata    (buf_rdata),
		.sd_buff_rdata(sd_buff_rdata)
	);

	sd_requester u_sd_requester (
		.clk_sys  (clk_sys),
		.areset   (areset),
		.rd_req   (rd_req),
		.wr_req   (wr_req),
		.req_drive(req_drive),
		.sd_ack   (sd_ack),
		.sd_rd    (sd_rd),
		.sd_wr    (sd_wr),
		.io_done  (io_done)
	);

	mount_tracker u_mount_tracker (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_size    (img_size),
		.img_type    (img_type),
		.mount       (mount)
	);

endmodule

`default_nettype wire

/* design/host_port.sv */
// Host register port of the disk bridge.
// Turns the host strobes into single-cycle buffer and request strobes,
// latches the LBA and builds the status byte and readback word.

`default_nettype none

module host_port import disk_bridge_pkg::*; #(
	parameter int BUF_AW = buf_aw
) (
	input  wire logic         clk_sys,
	input  wire logic         areset,
	input  wire host_ctrl_t   host_ctrl,
	input  wire host_word_u   host_data,
	input  wire logic         io_wr,
	input  wire logic         data_wr,
	input  wire logic         data_rd,
	input  wire logic [7:0]   buf_rdata,
	input  wire logic         io_done,
	input  wire mount_info_t  mount,
	output logic              buf_push,
	output logic [7:0]        buf_wdata,
	output logic              buf_pop,
	output logic              buf_rewind,
	output logic              rd_req,
	output logic              wr_req,
	output drive_idx_t        req_drive,
	output logic [31:0]       sd_lba,
	output host_status_t      host_status,
	output logic [31:0]       host_rdata
);

	// Strobe history
	logic wr_q1;
	logic wr_q2;
	logic rd_q;
	logic blrd_q;
	logic blwr_q;
	logic data_wr_rise;

	// Transfers since the last rewind, top bit marks a full sector
	logic [BUF_AW:0] xfer_cnt;

	// Data strobe passes two stages before its edge is taken
	assign data_wr_rise = wr_q1 & ~wr_q2;

	// ======================================================================
	// Strobe generation
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			wr_q1      <= 1'b0;
			wr_q2      <= 1'b0;
			rd_q       <= 1'b0;
			blrd_q     <= 1'b0;
			blwr_q     <= 1'b0;
			buf_push   <= 1'b0;
			buf_pop    <= 1'b0;
			buf_rewind <= 1'b0;
			rd_req     <= 1'b0;
			wr_req     <= 1'b0;
			xfer_cnt   <= '0;
		end else begin
			wr_q1  <= data_wr;
			wr_q2  <= wr_q1;
			rd_q   <= data_rd;
			blrd_q <= host_ctrl.block_rd;
			blwr_q <= host_ctrl.block_wr;

			// LBA writes leave the pointer alone
			buf_push   <= data_wr_rise & ~host_ctrl.lba_sel;
			// Pointer moves once the host has taken the byte
			buf_pop    <= rd_q & ~data_rd;
			buf_rewind <= io_wr;

			rd_req <= host_ctrl.block_rd & ~blrd_q;
			wr_req <= host_ctrl.block_wr & ~blwr_q;

			if (buf_rewind) begin
				xfer_cnt <= '0;
			end else if (buf_push || buf_pop) begin
				xfer_cnt <= xfer_cnt + 1'b1;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk_sys) begin
		if (data_wr_rise) begin
			buf_wdata <= host_data.octet.value;
			if (host_ctrl.lba_sel) begin
				sd_lba <= host_data.lba;
			end
		end
		// Drive numbers 0, 1 and 4 fold onto slots 0, 1 and 2
		req_drive <= {host_ctrl.drive[2], host_ctrl.drive[0]};
	end

	// ======================================================================
	// Readback
	// ======================================================================

	always_comb begin
		host_status.io_done  = io_done;
		host_status.mounted  = mount.mounted;
		host_status.fileno   = mount.fileno;
		host_status.filetype = mount.filetype;
		host_status.readonly = mount.readonly;
	end

	assign host_rdata = host_ctrl.lba_sel ? mount.filesize : {24'h000000, buf_rdata};

	// One block command at a time reaches the SD side
	ap_req_excl: assert property (@(posedge clk_sys) disable iff (areset)
		!(rd_req && wr_req));

	// Host stays within one sector between rewinds
	ap_sector_bound: assert property (@(posedge clk_sys) disable iff (areset)
		(buf_push || buf_pop) |-> !xfer_cnt[BUF_AW]);

endmodule

`default_nettype wire

/* design/mount_tracker.sv */
// Tracks the image most recently mounted by the SD service.
// Reports its file number, type, read-only flag and size, and toggles
// the mounted flag on every new mount so the host can spot changes.

`default_nettype none

module mount_tracker import disk_bridge_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,
	input  wire logic [num_drives-1:0] img_mounted,
	input  wire logic                  img_readonly,
	input  wire logic [31:0]           img_size,
	input  wire logic [1:0]            img_type,
	output mount_info_t                mount
);

	localparam int cart_slot = num_drives - 1;

	logic [num_drives-1:0] mounted_q;
	logic                  mount_rise;
	logic [2:0]            slot_fileno;

	// Any slot going high counts as a new mount
	assign mount_rise = |(img_mounted & ~mounted_q);

	// Highest slot wins when several bits rise together
	always_comb begin
		slot_fileno = fileno_d1;
		if (img_mounted[1]) begin
			slot_fileno = fileno_d2;
		end
		if (img_mounted[cart_slot]) begin
			slot_fileno = fileno_cart;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted_q     <= '0;
			mount.mounted <= 1'b0;
		end else begin
			mounted_q <= img_mounted;
			if (mount_rise) begin
				mount.mounted  <= ~mount.mounted;
				mount.fileno   <= slot_fileno;
				mount.filetype <= img_type;
				// Cartridge images are never written back
				mount.readonly <= img_readonly | img_mounted[cart_slot];
				mount.filesize <= img_size;
			end
		end
	end

endmodule

`default_nettype wire

/* design/sd_requester.sv */
// SD request side of the disk bridge.
// Holds one read and one write request bit per drive slot until the
// SD service acknowledges, then flags completion to the host.

`default_nettype none

module sd_requester import disk_bridge_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  areset,
	input  wire logic                  rd_req,
	input  wire logic                  wr_req,
	input  wire drive_idx_t            req_drive,
	input  wire logic [num_drives-1:0] sd_ack,
	output logic [num_drives-1:0]      sd_rd,
	output logic [num_drives-1:0]      sd_wr,
	output logic                       io_done
);

	logic ack_any;
	logic ack_q;

	assign ack_any = |sd_ack;

	// ======================================================================
	// Request bits and completion
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd   <= '0;
			sd_wr   <= '0;
			ack_q   <= 1'b0;
			io_done <= 1'b0;
		end else begin
			// New request overwrites whatever is pending
			if (rd_req) begin
				sd_rd[req_drive] <= 1'b1;
				io_done          <= 1'b0;
			end
			if (wr_req) begin
				sd_wr[req_drive] <= 1'b1;
				io_done          <= 1'b0;
			end

			// Any ack drops every request
			if (ack_any) begin
				sd_rd <= '0;
				sd_wr <= '0;
			end

			ack_q <= ack_any;
			// Transfer is over once the ack goes away
			if (ack_q && !ack_any) begin
				io_done <= 1'b1;
			end
		end
	end

	// Folded host drive number always lands on a real slot
	ap_slot_range: assert property (@(posedge clk_sys) disable iff (areset)
		(rd_req || wr_req) |-> (int'(req_drive) < num_drives));

endmodule

`default_nettype wire

/* design/sector_buffer.sv */
// Sector buffer between the host port and the SD image service.
// Host side goes through an auto-incrementing pointer, SD side is
// addressed directly. Read data on both sides arrives one cycle late.

`default_nettype none

module sector_buffer import disk_bridge_pkg::*; #(
	parameter int BUF_AW = buf_aw
) (
	input  wire logic              clk_sys,
	input  wire logic              areset,
	input  wire logic              buf_push,
	input  wire logic [7:0]        buf_wdata,
	input  wire logic              buf_pop,
	input  wire logic              buf_rewind,
	input  wire logic [BUF_AW-1:0] sd_buff_addr,
	input  wire logic [7:0]        sd_buff_wdata,
	input  wire logic              sd_buff_wr,
	output logic [7:0]             buf_rdata,
	output logic [7:0]             sd_buff_rdata
);

	localparam int depth = 2 ** BUF_AW;

	logic [7:0]        mem [depth];
	logic [BUF_AW-1:0] ptr;

	// ======================================================================
	// Host pointer
	// ======================================================================

	// Rewind wins over push and pop
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr <= '0;
		end else if (buf_rewind) begin
			ptr <= '0;
		end else if (buf_push || buf_pop) begin
			ptr <= ptr + 1'b1;
		end
	end

	// ======================================================================
	// Storage
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (buf_push) begin
			mem[ptr] <= buf_wdata;
		end
		// SD side takes the byte on an address clash
		if (sd_buff_wr) begin
			mem[sd_buff_addr] <= sd_buff_wdata;
		end
		buf_rdata     <= mem[ptr];
		sd_buff_rdata <= mem[sd_buff_addr];
	end

	// Host never fills and drains in the same cycle
	ap_push_pop: assert property (@(posedge clk_sys) disable iff (areset)
		!(buf_push && buf_pop));

endmodule

`default_nettype wire

/* files.f */
+incdir+include
design/disk_bridge_pkg.sv
design/host_port.sv
design/sector_buffer.sv
design/sd_requester.sv
design/mount_tracker.sv
design/disk_bridge_top.sv
test/disk_bridge_checker.sv
test/tb_disk_bridge.sv

/* include/check_codes.svh */
// Selector codes for the checks that the testbench hands to its checker.
// Included at the top of the testbench and of the checker.

`ifndef check_codes_svh
`define check_codes_svh

`define chk_rdata    3'd0
`define chk_sd_rdata 3'd1
`define chk_lba      3'd2
`define chk_req      3'd3
`define chk_status   3'd4

`endif

/* test/disk_bridge_checker.sv */
// Checker for the disk bridge testbench.
// Compares one DUT output per armed cycle against the expected value
// from the testbench model, and counts checks and errors.

`default_nettype none

`include "check_codes.svh"

module disk_bridge_checker import disk_bridge_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  check_en,
	input  wire logic [2:0]            check_sel,
	input  wire logic [31:0]           check_exp,
	input  wire logic [31:0]           host_rdata,
	input  wire host_status_t          host_status,
	input  wire logic [31:0]           sd_lba,
	input  wire logic [num_drives-1:0] sd_rd,
	input  wire logic [num_drives-1:0] sd_wr,
	input  wire logic [7:0]            sd_buff_rdata,
	output int                         check_count,
	output int                         error_count
);

	int          checks = 0;
	int          errors = 0;
	logic [31:0] seen;
	string       what;

	assign check_count = checks;
	assign error_count = errors;

	// Outputs are taken at the edge, before this edge updates them
	always @(posedge clk_sys) begin
		if (check_en) begin
			case (check_sel)
				`chk_rdata: begin
					seen = host_rdata;
					what = "host_rdata";
				end
				`chk_sd_rdata: begin
					seen = {24'h000000, sd_buff_rdata};
					what = "sd_buff_rdata";
				end
				`chk_lba: begin
					seen = sd_lba;
					what = "sd_lba";
				end
				`chk_req: begin
					seen = 32'({sd_wr, sd_rd});
					what = "sd_wr/sd_rd";
				end
				`chk_status: begin
					seen = {24'h000000, host_status};
					what = "host_status";
				end
				default: begin
					seen = 'x;
					what = "unknown output";
				end
			endcase
			checks++;
			if (seen !== check_exp) begin
				errors++;
				$display("Error at %0t: %s is %h, expected %h", $time, what, seen, check_exp);
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_disk_bridge.sv */
// Testbench for the disk block bridge.
// Mounts images, issues block requests, fills and drains the sector
// buffer from both sides and loads an LBA. The checker compares.

`default_nettype none

`include "check_codes.svh"

module tb_disk_bridge import disk_bridge_pkg::*; ();

	localparam int timeout_cycles = 64;
	localparam int fill_len       = 12;

	logic                  clk_sys;
	logic                  areset;
	host_ctrl_t            host_ctrl;
	host_word_u            host_data;
	logic                  io_wr;
	logic                  data_wr;
	logic                  data_rd;
	logic [num_drives-1:0] sd_ack;
	logic [buf_aw-1:0]     sd_buff_addr;
	logic [7:0]            sd_buff_wdata;
	logic                  sd_buff_wr;
	logic [num_drives-1:0] img_mounted;
	logic                  img_readonly;
	logic [31:0]           img_size;
	logic [1:0]            img_type;
	host_status_t          host_status;
	logic [31:0]           host_rdata;
	logic [31:0]           sd_lba;
	logic [num_drives-1:0] sd_rd;
	logic [num_drives-1:0] sd_wr;
	logic [7:0]            sd_buff_rdata;

	// Check requests to the checker
	logic        check_en;
	logic [2:0]  check_sel;
	logic [31:0] check_exp;
	int          check_count;
	int          error_count;

	// Model of the buffer and the status byte
	logic [7:0]   model [2 ** buf_aw];
	host_status_t exp_status;
	logic [31:0]  seed;

	disk_bridge_top #(.BUF_AW(buf_aw)) uut (
		.clk_sys(clk_sys), .areset(areset),
		.host_ctrl(host_ctrl), .host_data(host_data),
		.io_wr(io_wr), .data_wr(data_wr), .data_rd(data_rd),
		.host_status(host_status), .host_rdata(host_rdata),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr),
		.sd_buff_wdata(sd_buff_wdata), .sd_buff_wr(sd_buff_wr),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_size(img_size), .img_type(img_type),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_buff_rdata(sd_buff_rdata)
	);

	disk_bridge_checker u_checker (
		.clk_sys(clk_sys), .check_en(check_en), .check_sel(check_sel),
		.check_exp(check_exp), .host_rdata(host_rdata), .host_status(host_status),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_buff_rdata(sd_buff_rdata),
		.check_count(check_count), .error_count(error_count)
	);

	// ======================================================================
	// Reference functions
	// ======================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Host drives 0, 1 and 4 use request slots 0, 1 and 2
	function automatic int slot_of(input host_drive_t drive);
		case (drive)
			3'd0: return 0;
			3'd1: return 1;
			3'd4: return 2;
			default: return -1;
		endcase
	endfunction

	function automatic logic [2:0] fileno_of(input int slot);
		return (slot == 2) ? 3'd4 : 3'(slot);
	endfunction

	// ======================================================================
	// Stimulus helpers, entered just after a rising edge
	// ======================================================================

	task automatic step(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic expect_value(input logic [2:0] sel, input logic [31:0] value);
		check_sel = sel;
		check_exp = value;
		check_en  = 1'b1;
		step(1);
		check_en  = 1'b0;
	endtask

	// Edge is seen two cycles in, the write lands one cycle later
	task automatic host_write(input logic [31:0] word);
		host_data.lba = word;
		data_wr = 1'b1;
		step(1);
		data_wr = 1'b0;
		step(3);
	endtask

	task automatic rewind_pointer();
		io_wr = 1'b1;
		step(1);
		io_wr = 1'b0;
		step(2);
	endtask

	task automatic give_up(input string what);
		$display("Timeout while waiting for %s", what);
		$display("test failed");
		$finish;
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		while ((sd_rd | sd_wr) == '0 && n < timeout_cycles) begin
			step(1);
			n++;
		end
		if ((sd_rd | sd_wr) == '0) give_up("an SD request bit");
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!host_status.io_done && n < timeout_cycles) begin
			step(1);
			n++;
		end
		if (!host_status.io_done) give_up("io_done after the acknowledge");
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		int slot;
		int addr;
		logic [31:0] lba;
		areset        = 1'b1;
		host_ctrl     = '0;
		host_data     = '0;
		io_wr         = 1'b0;
		data_wr       = 1'b0;
		data_rd       = 1'b0;
		sd_ack        = '0;
		sd_buff_addr  = '0;
		sd_buff_wdata = '0;
		sd_buff_wr    = 1'b0;
		img_mounted   = '0;
		img_readonly  = 1'b0;
		img_size      = '0;
		img_type      = '0;
		check_en      = 1'b0;
		check_sel     = '0;
		check_exp     = '0;
		exp_status    = '0;
		seed          = 32'hd9dab5bc;
		step(2);
		areset = 1'b0;

		// Request bits come out of reset clear
		expect_value(`chk_req, 32'd0);

		// Mount each slot, mounted toggles every time
		for (slot = 0; slot < num_drives; slot++) begin
			seed = lcg_next(seed);
			img_size     = seed;
			img_type     = seed[31:30];
			// Slot 0 mounts read-only, the cartridge must be forced
			img_readonly = (slot == 0);
			img_mounted[slot] = 1'b1;
			step(2);
			img_mounted = '0;
			step(1);
			exp_status.mounted  = ~exp_status.mounted;
			exp_status.fileno   = fileno_of(slot);
			exp_status.filetype = img_type;
			exp_status.readonly = img_readonly | (slot == 2);
			expect_value(`chk_status, {24'h000000, exp_status});
			host_ctrl.lba_sel = 1'b1;
			expect_value(`chk_rdata, img_size);
			host_ctrl.lba_sel = 1'b0;
		end

		// Block read then block write on drives 0, 1 and 4
		for (int i = 0; i < 6; i++) begin
			host_ctrl.drive    = (i / 2 == 2) ? 3'd4 : 3'(i / 2);
			host_ctrl.block_rd = (i % 2 == 0);
			host_ctrl.block_wr = (i % 2 == 1);
			slot = slot_of(host_ctrl.drive);
			wait_request();
			host_ctrl.block_rd = 1'b0;
			host_ctrl.block_wr = 1'b0;
			exp_status.io_done = 1'b0;
			expect_value(`chk_req, 32'd1 << (slot + (i % 2) * num_drives));
			expect_value(`chk_status, {24'h000000, exp_status});
			sd_ack[slot] = 1'b1;
			step(2);
			sd_ack = '0;
			wait_done();
			exp_status.io_done = 1'b1;
			expect_value(`chk_req, 32'd0);
			expect_value(`chk_status, {24'h000000, exp_status});
		end

		// Host fill, then an LBA load that must leave the pointer alone
		rewind_pointer();
		for (addr = 0; addr < fill_len; addr++) begin
			seed = lcg_next(seed);
			model[addr] = seed[23:16];
			host_write({24'h000000, seed[23:16]});
		end
		seed = lcg_next(seed);
		lba  = seed;
		host_ctrl.lba_sel = 1'b1;
		host_write(lba);
		host_ctrl.lba_sel = 1'b0;
		expect_value(`chk_lba, lba);
		seed = lcg_next(seed);
		model[fill_len] = seed[23:16];
		host_write({24'h000000, seed[23:16]});
		for (addr = 0; addr <= fill_len; addr++) begin
			sd_buff_addr = addr[buf_aw-1:0];
			step(1);
			expect_value(`chk_sd_rdata, {24'h000000, model[addr]});
		end

		// SD side fills, host drains in address order
		for (addr = 0; addr < fill_len; addr++) begin
			seed = lcg_next(seed);
			model[addr]   = seed[15:8];
			sd_buff_addr  = addr[buf_aw-1:0];
			sd_buff_wdata = seed[15:8];
			sd_buff_wr    = 1'b1;
			step(1);
		end
		sd_buff_wr = 1'b0;
		rewind_pointer();
		for (addr = 0; addr < fill_len; addr++) begin
			expect_value(`chk_rdata, {24'h000000, model[addr]});
			data_rd = 1'b1;
			step(1);
			data_rd = 1'b0;
			step(3);
		end

		// Reset clears mounted and io_done
		areset = 1'b1;
		step(2);
		areset = 1'b0;
		exp_status.mounted = 1'b0;
		exp_status.io_done = 1'b0;
		expect_value(`chk_status, {24'h000000, exp_status});

		step(1);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
